// File: design/mipsTypesPkg.sv
package mipsTypesPkg;

    ////////////////////////////////////////
    // Basic widths
    ////////////////////////////////////////
    typedef logic [31:0] word_t;     // Data or address word
    typedef logic [4:0]  regAddr_t;  // GPR number
    typedef logic [5:0]  opcode_t;
    typedef logic [5:0]  funct_t;
    typedef logic [4:0]  shamt_t;
    typedef logic [4:0]  excCode_t;  // Cause.ExcCode style

    // Boot and exception entry points
    localparam word_t RESET_PC   = 32'hBFC0_0000;
    localparam word_t EXC_VECTOR = 32'hBFC0_0380;

    localparam excCode_t EXC_NONE = 5'h00;
    localparam excCode_t EXC_RI   = 5'h0A;  // Reserved instruction
    localparam excCode_t EXC_OV   = 5'h0C;  // Signed overflow

    ////////////////////////////////////////
    // Opcodes
    ////////////////////////////////////////
    localparam opcode_t OP_SPECIAL = 6'h00;  // Register form, see funct
    localparam opcode_t OP_ADDI    = 6'h08;
    localparam opcode_t OP_ADDIU   = 6'h09;
    localparam opcode_t OP_SLTI    = 6'h0A;
    localparam opcode_t OP_SLTIU   = 6'h0B;
    localparam opcode_t OP_ANDI    = 6'h0C;
    localparam opcode_t OP_ORI     = 6'h0D;
    localparam opcode_t OP_XORI    = 6'h0E;
    localparam opcode_t OP_LUI     = 6'h0F;

    // Funct codes under OP_SPECIAL
    localparam funct_t FN_SLL  = 6'h00;
    localparam funct_t FN_SRL  = 6'h02;
    localparam funct_t FN_SRA  = 6'h03;
    localparam funct_t FN_ADD  = 6'h20;
    localparam funct_t FN_ADDU = 6'h21;
    localparam funct_t FN_SUB  = 6'h22;
    localparam funct_t FN_SUBU = 6'h23;
    localparam funct_t FN_AND  = 6'h24;
    localparam funct_t FN_OR   = 6'h25;
    localparam funct_t FN_XOR  = 6'h26;
    localparam funct_t FN_NOR  = 6'h27;
    localparam funct_t FN_SLT  = 6'h2A;
    localparam funct_t FN_SLTU = 6'h2B;

endpackage

// File: design/pipeTypesPkg.sv
package pipeTypesPkg;
    import mipsTypesPkg::*;

    // Operation selected by decode, carried into execute
    typedef enum logic [3:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_NOR,
        ALU_SLT,
        ALU_SLTU,
        ALU_SLL,
        ALU_SRL,
        ALU_SRA,
        ALU_LUI
    } aluOp_t;

    // Fetch unit states
    typedef enum logic [1:0] {
        S_IDLE,     // stb low between reads
        S_REQUEST,  // Read outstanding
        S_DROP      // Read outstanding, data to be discarded
    } fsmState_t;

    ////////////////////////////////////////
    // Ports
    ////////////////////////////////////////
    typedef struct packed {
        logic  cyc;
        logic  stb;
        word_t adr;
    } wbReq_t;

    typedef struct packed {
        word_t      pc;
        logic [3:0] wen;    // All ones on a register write
        regAddr_t   wnum;
        word_t      wdata;
    } wbTrace_t;

    ////////////////////////////////////////
    // Stage to stage
    ////////////////////////////////////////
    typedef struct packed {
        logic     valid;
        word_t    pc;
        aluOp_t   aluOp;
        word_t    rsVal;
        word_t    rtVal;
        word_t    imm;      // Already extended
        logic     useImm;
        shamt_t   shamt;
        regAddr_t rs;
        regAddr_t rt;
        regAddr_t dest;
        logic     write;
        logic     ovEn;     // ADD, SUB, ADDI trap on overflow
        excCode_t exc;      // Pending code from decode
    } decodedOp_t;

    typedef struct packed {
        logic     valid;
        word_t    pc;
        regAddr_t dest;
        logic     write;
        word_t    result;
        excCode_t exc;
    } execResult_t;

endpackage

// File: design/instrFetch.sv
`timescale 1ns/1ps

module instrFetch (
    input  logic                 clk,
    input  logic                 rst,
    output pipeTypesPkg::wbReq_t wbReq_o,
    input  logic                 wbAck_i,
    input  mipsTypesPkg::word_t  wbDat_i,
    input  logic                 flush_i,
    output mipsTypesPkg::word_t  instr_o,
    output mipsTypesPkg::word_t  instrPc_o,
    output logic                 instrValid_o
);
    import mipsTypesPkg::*;
    import pipeTypesPkg::*;

    fsmState_t state;
    word_t     pc;         // Also the bus address
    logic      busy;

    ////////////////////////////////////////
    // Wishbone classic read master
    ////////////////////////////////////////
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state <= S_IDLE;
            pc    <= RESET_PC;
        end else begin
            case (state)
                S_IDLE: begin
                    if (flush_i) begin
                        pc <= EXC_VECTOR;
                    end
                    state <= S_REQUEST;
                end
                S_REQUEST: begin
                    if (wbAck_i) begin
                        pc    <= flush_i ? EXC_VECTOR : pc + 32'd4;
                        state <= S_IDLE;      // stb low for one cycle
                    end else if (flush_i) begin
                        state <= S_DROP;      // adr held until the slave answers
                    end
                end
                S_DROP: begin
                    if (wbAck_i) begin
                        pc    <= EXC_VECTOR;
                        state <= S_IDLE;
                    end
                end
                default: state <= S_IDLE;
            endcase
        end
    end

    assign busy = (state != S_IDLE);

    always_comb begin
        wbReq_o.cyc = busy;
        wbReq_o.stb = busy;
        wbReq_o.adr = pc;
    end

    // Data is valid in the ack cycle, decode samples it on the same edge
    assign instr_o      = wbDat_i;
    assign instrPc_o    = pc;
    assign instrValid_o = (state == S_REQUEST) && wbAck_i && !flush_i;

endmodule

// File: design/instrDecode.sv
`timescale 1ns/1ps

module instrDecode (
    input  logic                     clk,
    input  logic                     rst,
    input  logic                     flush_i,
    input  mipsTypesPkg::word_t      instr_i,
    input  mipsTypesPkg::word_t      instrPc_i,
    input  logic                     instrValid_i,
    output mipsTypesPkg::regAddr_t   rsAddr_o,
    output mipsTypesPkg::regAddr_t   rtAddr_o,
    input  mipsTypesPkg::word_t      rsData_i,
    input  mipsTypesPkg::word_t      rtData_i,
    output pipeTypesPkg::decodedOp_t op_o
);
    import mipsTypesPkg::*;
    import pipeTypesPkg::*;

    word_t       instrD;
    word_t       pcD;
    logic        validD;

    opcode_t     opcode;
    funct_t      funct;
    regAddr_t    rs;
    regAddr_t    rt;
    regAddr_t    rd;
    shamt_t      shamt;
    logic [15:0] imm16;

    aluOp_t      aluOp;
    logic        legal;
    logic        immForm;
    logic        zeroExt;
    logic        ovEn;

    ////////////////////////////////////////
    // Decode register
    ////////////////////////////////////////
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            validD <= 1'b0;
        end else begin
            validD <= instrValid_i && !flush_i;
        end
    end

    always_ff @(posedge clk) begin
        if (instrValid_i) begin
            instrD <= instr_i;
            pcD    <= instrPc_i;
        end
    end

    // Field split
    assign opcode = instrD[31:26];
    assign rs     = instrD[25:21];
    assign rt     = instrD[20:16];
    assign rd     = instrD[15:11];
    assign shamt  = instrD[10:6];
    assign funct  = instrD[5:0];
    assign imm16  = instrD[15:0];

    assign rsAddr_o = rs;
    assign rtAddr_o = rt;

    always_comb begin
        aluOp = ALU_ADD;
        legal = 1'b1;
        case (opcode)
            OP_SPECIAL: begin
                case (funct)
                    FN_ADD, FN_ADDU: aluOp = ALU_ADD;
                    FN_SUB, FN_SUBU: aluOp = ALU_SUB;
                    FN_AND:          aluOp = ALU_AND;
                    FN_OR:           aluOp = ALU_OR;
                    FN_XOR:          aluOp = ALU_XOR;
                    FN_NOR:          aluOp = ALU_NOR;
                    FN_SLT:          aluOp = ALU_SLT;
                    FN_SLTU:         aluOp = ALU_SLTU;
                    FN_SLL:          aluOp = ALU_SLL;
                    FN_SRL:          aluOp = ALU_SRL;
                    FN_SRA:          aluOp = ALU_SRA;
                    default:         legal = 1'b0;
                endcase
            end
            OP_ADDI, OP_ADDIU: aluOp = ALU_ADD;
            OP_SLTI:           aluOp = ALU_SLT;
            OP_SLTIU:          aluOp = ALU_SLTU;  // Compares against the sign-extended imm
            OP_ANDI:           aluOp = ALU_AND;
            OP_ORI:            aluOp = ALU_OR;
            OP_XORI:           aluOp = ALU_XOR;
            OP_LUI:            aluOp = ALU_LUI;
            default:           legal = 1'b0;  // Everything else is RI
        endcase
    end

    assign immForm = (opcode != OP_SPECIAL);
    assign zeroExt = (opcode == OP_ANDI) || (opcode == OP_ORI) || (opcode == OP_XORI);
    assign ovEn    = (opcode == OP_ADDI)
                  || ((opcode == OP_SPECIAL) && ((funct == FN_ADD) || (funct == FN_SUB)));

    always_comb begin
        op_o.valid  = validD;
        op_o.pc     = pcD;
        op_o.aluOp  = aluOp;
        op_o.rsVal  = rsData_i;
        op_o.rtVal  = rtData_i;
        op_o.imm    = zeroExt ? {16'h0000, imm16} : {{16{imm16[15]}}, imm16};
        op_o.useImm = immForm;
        op_o.shamt  = shamt;
        op_o.rs     = rs;
        op_o.rt     = rt;
        op_o.dest   = immForm ? rt : rd;
        op_o.write  = legal;
        op_o.ovEn   = ovEn;
        op_o.exc    = legal ? EXC_NONE : EXC_RI;
    end

endmodule

// File: design/regFile.sv
`timescale 1ns/1ps

module regFile (
    input  logic                   clk,
    input  mipsTypesPkg::regAddr_t rsAddr_i,
    input  mipsTypesPkg::regAddr_t rtAddr_i,
    output mipsTypesPkg::word_t    rsData_o,
    output mipsTypesPkg::word_t    rtData_o,
    input  logic                   we_i,
    input  mipsTypesPkg::regAddr_t wAddr_i,
    input  mipsTypesPkg::word_t    wData_i
);
    import mipsTypesPkg::*;

    word_t regs [32];

    always_ff @(posedge clk) begin
        if (we_i && (wAddr_i != '0)) begin
            regs[wAddr_i] <= wData_i;
        end
    end

    // $zero first, then bypass of the write in this cycle
    function automatic word_t readPort(input regAddr_t addr);
        if (addr == '0) begin
            return '0;
        end else if (we_i && (wAddr_i == addr)) begin
            return wData_i;
        end
        return regs[addr];
    endfunction

    assign rsData_o = readPort(rsAddr_i);
    assign rtData_o = readPort(rtAddr_i);

endmodule

// File: design/aluExecute.sv
`timescale 1ns/1ps

module aluExecute (
    input  logic                      clk,
    input  logic                      rst,
    input  logic                      flush_i,
    input  pipeTypesPkg::decodedOp_t  op_i,
    input  pipeTypesPkg::execResult_t fwd_i,
    output pipeTypesPkg::execResult_t res_o
);
    import mipsTypesPkg::*;
    import pipeTypesPkg::*;

    decodedOp_t opE;
    logic       fwdOk;
    word_t      srcA;
    word_t      srcB;
    word_t      opB;
    word_t      sum;
    word_t      diff;
    word_t      result;
    logic       addOv;
    logic       subOv;
    logic       overflow;

    // Execute register, only valid is reset
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            opE.valid <= 1'b0;
        end else begin
            opE       <= op_i;
            opE.valid <= op_i.valid && !flush_i;
        end
    end

    ////////////////////////////////////////
    // Forwarding from the result register
    ////////////////////////////////////////
    assign fwdOk = fwd_i.valid && fwd_i.write && (fwd_i.exc == EXC_NONE) && (fwd_i.dest != '0);

    assign srcA = (fwdOk && (fwd_i.dest == opE.rs)) ? fwd_i.result : opE.rsVal;
    assign srcB = (fwdOk && (fwd_i.dest == opE.rt)) ? fwd_i.result : opE.rtVal;
    assign opB  = opE.useImm ? opE.imm : srcB;

    assign sum  = srcA + opB;
    assign diff = srcA - opB;

    always_comb begin
        case (opE.aluOp)
            ALU_ADD:  result = sum;
            ALU_SUB:  result = diff;
            ALU_AND:  result = srcA & opB;
            ALU_OR:   result = srcA | opB;
            ALU_XOR:  result = srcA ^ opB;
            ALU_NOR:  result = ~(srcA | opB);
            ALU_SLT:  result = {31'd0, $signed(srcA) < $signed(opB)};
            ALU_SLTU: result = {31'd0, srcA < opB};
            ALU_SLL:  result = opB << opE.shamt;        // Shifts act on rt
            ALU_SRL:  result = opB >> opE.shamt;
            ALU_SRA:  result = word_t'($signed(opB) >>> opE.shamt);
            ALU_LUI:  result = {opE.imm[15:0], 16'h0000};
            default:  result = sum;
        endcase
    end

    // Signed overflow: operand signs vs result sign
    assign addOv    = (srcA[31] == opB[31]) && (sum[31] != srcA[31]);
    assign subOv    = (srcA[31] != opB[31]) && (diff[31] != srcA[31]);
    assign overflow = opE.ovEn && ((opE.aluOp == ALU_SUB) ? subOv : addOv);

    always_comb begin
        res_o.valid  = opE.valid;
        res_o.pc     = opE.pc;
        res_o.dest   = opE.dest;
        res_o.write  = opE.write;
        res_o.result = result;
        if (opE.exc != EXC_NONE) begin
            res_o.exc = opE.exc;  // RI wins over OV
        end else begin
            res_o.exc = overflow ? EXC_OV : EXC_NONE;
        end
    end

endmodule

// File: design/resultStage.sv
`timescale 1ns/1ps

module resultStage (
    input  logic                      clk,
    input  logic                      rst,
    input  pipeTypesPkg::execResult_t res_i,
    output pipeTypesPkg::execResult_t fwd_o,
    output logic                      we_o,
    output mipsTypesPkg::regAddr_t    wAddr_o,
    output mipsTypesPkg::word_t       wData_o,
    output logic                      flush_o,
    output pipeTypesPkg::wbTrace_t    trace_o,
    output logic                      excValid_o,
    output mipsTypesPkg::excCode_t    excCode_o,
    output mipsTypesPkg::word_t       excPc_o
);
    import mipsTypesPkg::*;
    import pipeTypesPkg::*;

    execResult_t resR;
    logic        excNow;
    logic        doWrite;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            resR.valid <= 1'b0;
        end else begin
            resR       <= res_i;
            resR.valid <= res_i.valid && !excNow;  // Younger op is killed by the flush
        end
    end

    assign excNow  = resR.valid && (resR.exc != EXC_NONE);
    assign doWrite = resR.valid && resR.write && (resR.exc == EXC_NONE) && (resR.dest != '0);

    assign fwd_o   = resR;
    assign we_o    = doWrite;
    assign wAddr_o = resR.dest;
    assign wData_o = resR.result;
    assign flush_o = excNow;

    ////////////////////////////////////////
    // Trace and exception report
    ////////////////////////////////////////
    always_comb begin
        trace_o.pc    = resR.pc;
        trace_o.wen   = doWrite ? 4'b1111 : 4'b0000;
        trace_o.wnum  = resR.dest;
        trace_o.wdata = resR.result;
    end

    assign excValid_o = excNow;
    assign excCode_o  = resR.exc;
    assign excPc_o    = resR.pc;

endmodule

// File: design/mipsPipe.sv
`timescale 1ns/1ps

module mipsPipe (
    input  logic                   clk,
    input  logic                   rst,
    output pipeTypesPkg::wbReq_t   wbReq_o,
    input  logic                   wbAck_i,
    input  mipsTypesPkg::word_t    wbDat_i,
    output pipeTypesPkg::wbTrace_t trace_o,
    output logic                   excValid_o,
    output mipsTypesPkg::excCode_t excCode_o,
    output mipsTypesPkg::word_t    excPc_o
);
    import mipsTypesPkg::*;
    import pipeTypesPkg::*;

    // Fetch to decode
    word_t       instr;
    word_t       instrPc;
    logic        instrValid;

    // Register file ports
    regAddr_t    rsAddr;
    regAddr_t    rtAddr;
    word_t       rsData;
    word_t       rtData;
    logic        rfWe;
    regAddr_t    rfWAddr;
    word_t       rfWData;

    decodedOp_t  decOp;
    execResult_t execRes;
    execResult_t fwdRes;   // Result register fed back to execute
    logic        flush;

    instrFetch uFetch (
        .clk          (clk),
        .rst          (rst),
        .wbReq_o      (wbReq_o),
        .wbAck_i      (wbAck_i),
        .wbDat_i      (wbDat_i),
        .flush_i      (flush),
        .instr_o      (instr),
        .instrPc_o    (instrPc),
        .instrValid_o (instrValid)
    );

    instrDecode uDecode (
        .clk          (clk),
        .rst          (rst),
        .flush_i      (flush),
        .instr_i      (instr),
        .instrPc_i    (instrPc),
        .instrValid_i (instrValid),
        .rsAddr_o     (rsAddr),
        .rtAddr_o     (rtAddr),
        .rsData_i     (rsData),
        .rtData_i     (rtData),
        .op_o         (decOp)
    );

    regFile uRegFile (
        .clk      (clk),
        .rsAddr_i (rsAddr),
        .rtAddr_i (rtAddr),
        .rsData_o (rsData),
        .rtData_o (rtData),
        .we_i     (rfWe),
        .wAddr_i  (rfWAddr),
        .wData_i  (rfWData)
    );

    aluExecute uExecute (
        .clk     (clk),
        .rst     (rst),
        .flush_i (flush),
        .op_i    (decOp),
        .fwd_i   (fwdRes),
        .res_o   (execRes)
    );

    resultStage uResult (
        .clk        (clk),
        .rst        (rst),
        .res_i      (execRes),
        .fwd_o      (fwdRes),
        .we_o       (rfWe),
        .wAddr_o    (rfWAddr),
        .wData_o    (rfWData),
        .flush_o    (flush),
        .trace_o    (trace_o),
        .excValid_o (excValid_o),
        .excCode_o  (excCode_o),
        .excPc_o    (excPc_o)
    );

endmodule

// File: tests/mipsPipe_asserts.sv
`timescale 1ns/1ps

module mipsPipe_asserts (
    input logic                   clk,
    input logic                   rst,
    input pipeTypesPkg::wbReq_t   wbReq_i,
    input logic                   wbAck_i,
    input pipeTypesPkg::wbTrace_t trace_i,
    input logic                   excValid_i
);

    ////////////////////////////////////////
    // Wishbone classic read master
    ////////////////////////////////////////
    reqHeld: assert property (@(posedge clk) disable iff (rst)
        (wbReq_i.stb && !wbAck_i) |=> (wbReq_i.stb && $stable(wbReq_i.adr)))
        else $error("Wishbone stb or adr changed before ack");

    stbInCycle: assert property (@(posedge clk) disable iff (rst)
        wbReq_i.stb |-> wbReq_i.cyc)
        else $error("Wishbone stb high without cyc");

    // Flush kills the younger ops
    noTraceAfterExc: assert property (@(posedge clk) disable iff (rst)
        excValid_i |=> (trace_i.wen == 4'b0000))
        else $error("Register write traced in the cycle after an exception");

endmodule

bind mipsPipe mipsPipe_asserts uAsserts (
    .clk        (clk),
    .rst        (rst),
    .wbReq_i    (wbReq_o),
    .wbAck_i    (wbAck_i),
    .trace_i    (trace_o),
    .excValid_i (excValid_o)
);

// File: tests/mipsPipe_tb.sv
`timescale 1ns/1ps

module mipsPipe_tb;
    import mipsTypesPkg::*;
    import pipeTypesPkg::*;

    localparam int unsigned SEED         = 32'h2f0be376;
    localparam int          RESET_CYCLES = 16;
    localparam int          ROW_CYCLES   = 20;  // Watchdog budget per table row
    localparam int          QUIET_CYCLES = 40;

    typedef enum logic [1:0] {
        EV_NONE,   // Flushed or writes $zero
        EV_TRACE,
        EV_EXC
    } evKind_t;

    typedef struct packed {
        word_t    pc;
        word_t    instr;
        evKind_t  kind;
        regAddr_t num;
        word_t    value;  // Register value, or exception code
    } progRow_t;

    logic     clk;
    logic     rst;
    wbReq_t   wbReq;
    logic     wbAck;
    word_t    wbDat;
    wbTrace_t trace;
    logic     excValid;
    excCode_t excCode;
    word_t    excPc;

    progRow_t    rows [$];
    word_t       progMem [word_t];
    word_t       curPc;
    int          waitLeft;
    int          errors;
    int          checked;
    int          curRow;
    logic        tableReady;

    evKind_t     gotKind;
    word_t       gotPc;
    regAddr_t    gotNum;
    word_t       gotValue;
    logic [3:0]  gotWen;

    mipsPipe UUT (
        .clk        (clk),
        .rst        (rst),
        .wbReq_o    (wbReq),
        .wbAck_i    (wbAck),
        .wbDat_i    (wbDat),
        .trace_o    (trace),
        .excValid_o (excValid),
        .excCode_o  (excCode),
        .excPc_o    (excPc)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    ////////////////////////////////////////
    // Instruction encoding and table
    ////////////////////////////////////////
    function automatic word_t rType(input funct_t fn, input regAddr_t rd, input regAddr_t rs,
                                    input regAddr_t rt, input shamt_t sa);
        return {OP_SPECIAL, rs, rt, rd, sa, fn};
    endfunction

    function automatic word_t iType(input opcode_t op, input regAddr_t rt, input regAddr_t rs,
                                    input logic [15:0] imm);
        return {op, rs, rt, imm};
    endfunction

    // ORI $zero with an address hash so it is never traced
    function automatic word_t fillWord(input word_t adr);
        return {OP_ORI, 5'd0, 5'd0, adr[31:16] ^ adr[15:0]};
    endfunction

    function automatic string kindText(input evKind_t kind);
        case (kind)
            EV_TRACE: return "trace";
            EV_EXC:   return "exception";
            default:  return "no event";
        endcase
    endfunction

    task automatic addRow(input word_t instr, input evKind_t kind, input regAddr_t num,
                          input word_t value);
        rows.push_back('{pc: curPc, instr: instr, kind: kind, num: num, value: value});
        curPc = curPc + 32'd4;
    endtask

    // Rows in execution order where the vector program runs twice
    task automatic buildProgram();
        curPc = 32'hBFC0_0000;
        addRow(iType(OP_ORI,   5'd1, 5'd0, 16'h1234), EV_TRACE, 5'd1, 32'h0000_1234);
        addRow(iType(OP_ADDIU, 5'd2, 5'd0, 16'hFFFF), EV_TRACE, 5'd2, 32'hFFFF_FFFF);
        addRow(iType(OP_ANDI,  5'd3, 5'd2, 16'h8001), EV_TRACE, 5'd3, 32'h0000_8001);
        addRow(iType(OP_XORI,  5'd4, 5'd1, 16'hFFFF), EV_TRACE, 5'd4, 32'h0000_EDCB);
        addRow(iType(OP_LUI,   5'd5, 5'd0, 16'h8000), EV_TRACE, 5'd5, 32'h8000_0000);
        addRow(iType(OP_ADDI,  5'd6, 5'd1, 16'hFFFC), EV_TRACE, 5'd6, 32'h0000_1230);
        addRow(iType(OP_SLTI,  5'd7, 5'd2, 16'h0001), EV_TRACE, 5'd7, 32'h0000_0001);
        addRow(iType(OP_SLTIU, 5'd8, 5'd1, 16'hFFFF), EV_TRACE, 5'd8, 32'h0000_0001);
        addRow(rType(FN_ADDU, 5'd9,  5'd1,  5'd4, 5'd0), EV_TRACE, 5'd9,  32'h0000_FFFF);
        addRow(rType(FN_SUB,  5'd10, 5'd1,  5'd6, 5'd0), EV_TRACE, 5'd10, 32'h0000_0004);
        addRow(rType(FN_SUBU, 5'd11, 5'd6,  5'd1, 5'd0), EV_TRACE, 5'd11, 32'hFFFF_FFFC);
        addRow(rType(FN_AND,  5'd12, 5'd2,  5'd4, 5'd0), EV_TRACE, 5'd12, 32'h0000_EDCB);
        addRow(rType(FN_OR,   5'd13, 5'd5,  5'd1, 5'd0), EV_TRACE, 5'd13, 32'h8000_1234);
        addRow(rType(FN_XOR,  5'd14, 5'd13, 5'd2, 5'd0), EV_TRACE, 5'd14, 32'h7FFF_EDCB);
        addRow(rType(FN_NOR,  5'd15, 5'd1,  5'd0, 5'd0), EV_TRACE, 5'd15, 32'hFFFF_EDCB);
        addRow(rType(FN_SLT,  5'd16, 5'd5,  5'd1, 5'd0), EV_TRACE, 5'd16, 32'h0000_0001);
        addRow(rType(FN_SLTU, 5'd17, 5'd5,  5'd1, 5'd0), EV_TRACE, 5'd17, 32'h0000_0000);
        addRow(rType(FN_SLL,  5'd18, 5'd0,  5'd1, 5'd4), EV_TRACE, 5'd18, 32'h0001_2340);
        addRow(rType(FN_SRL,  5'd19, 5'd0,  5'd5, 5'd31), EV_TRACE, 5'd19, 32'h0000_0001);
        addRow(rType(FN_SRA,  5'd20, 5'd0,  5'd5, 5'd4), EV_TRACE, 5'd20, 32'hF800_0000);
        // Dependent chain
        addRow(rType(FN_ADD,  5'd21, 5'd18, 5'd19, 5'd0), EV_TRACE, 5'd21, 32'h0001_2341);
        addRow(iType(OP_ADDIU, 5'd21, 5'd21, 16'h00FF), EV_TRACE, 5'd21, 32'h0001_2440);
        addRow(rType(FN_OR, 5'd0, 5'd1, 5'd2, 5'd0), EV_NONE, 5'd0, 32'h0);
        addRow(iType(OP_ADDIU, 5'd22, 5'd0, 16'h0005), EV_TRACE, 5'd22, 32'h0000_0005);
        // Operands for the vector program
        addRow(iType(OP_ADDIU, 5'd24, 5'd0, 16'hFFFE), EV_TRACE, 5'd24, 32'hFFFF_FFFE);
        addRow(rType(FN_ADDU, 5'd25, 5'd5, 5'd0, 5'd0), EV_TRACE, 5'd25, 32'h8000_0000);
        addRow(iType(OP_ORI, 5'd26, 5'd0, 16'h5A5A), EV_TRACE, 5'd26, 32'h0000_5A5A);
        addRow(32'h8C01_0000, EV_EXC, 5'd0, 32'h0000_000A);  // LW is reserved here
        addRow(iType(OP_ORI, 5'd27, 5'd0, 16'h0001), EV_NONE, 5'd0, 32'h0);
        addRow(iType(OP_ORI, 5'd28, 5'd0, 16'h0002), EV_NONE, 5'd0, 32'h0);

        // First pass overflows and the second does not
        curPc = 32'hBFC0_0380;
        addRow(iType(OP_ADDIU, 5'd24, 5'd24, 16'h0001), EV_TRACE, 5'd24, 32'hFFFF_FFFF);
        addRow(rType(FN_OR,   5'd29, 5'd26, 5'd0,  5'd0), EV_TRACE, 5'd29, 32'h0000_5A5A);
        addRow(rType(FN_ADDU, 5'd30, 5'd24, 5'd25, 5'd0), EV_TRACE, 5'd30, 32'h7FFF_FFFF);
        addRow(rType(FN_ADD,  5'd26, 5'd24, 5'd25, 5'd0), EV_EXC, 5'd0, 32'h0000_000C);
        addRow(iType(OP_ORI, 5'd31, 5'd26, 16'h0001), EV_NONE, 5'd0, 32'h0);
        addRow(rType(FN_SUB, 5'd27, 5'd26, 5'd25, 5'd0), EV_NONE, 5'd0, 32'h0);

        curPc = 32'hBFC0_0380;
        addRow(iType(OP_ADDIU, 5'd24, 5'd24, 16'h0001), EV_TRACE, 5'd24, 32'h0000_0000);
        addRow(rType(FN_OR,   5'd29, 5'd26, 5'd0,  5'd0), EV_TRACE, 5'd29, 32'h0000_5A5A);
        addRow(rType(FN_ADDU, 5'd30, 5'd24, 5'd25, 5'd0), EV_TRACE, 5'd30, 32'h8000_0000);
        addRow(rType(FN_ADD,  5'd26, 5'd24, 5'd25, 5'd0), EV_TRACE, 5'd26, 32'h8000_0000);
        addRow(iType(OP_ORI, 5'd31, 5'd26, 16'h0001), EV_TRACE, 5'd31, 32'h8000_0001);
        addRow(rType(FN_SUB, 5'd27, 5'd26, 5'd25, 5'd0), EV_TRACE, 5'd27, 32'h0000_0000);
    endtask

    ////////////////////////////////////////
    // Wishbone instruction memory
    ////////////////////////////////////////
    always @(posedge clk) begin
        if (rst) begin
            wbAck <= 1'b0;
        end else if (wbAck) begin
            wbAck <= 1'b0;  // Single-cycle ack
        end else if (wbReq.cyc && wbReq.stb) begin
            if (waitLeft == 0) begin
                wbAck    <= 1'b1;
                wbDat    <= progMem.exists(wbReq.adr) ? progMem[wbReq.adr] : fillWord(wbReq.adr);
                waitLeft <= $urandom % 4;
            end else begin
                waitLeft <= waitLeft - 1;
            end
        end
    end

    // Next trace or exception sampled on the falling edge
    task automatic waitEvent(output evKind_t kind, output word_t pc, output regAddr_t num,
                             output word_t value, output logic [3:0] wen);
        do begin
            @(negedge clk);
        end while (!excValid && (trace.wen == 4'b0000));
        wen = trace.wen;
        if (excValid) begin
            kind  = EV_EXC;
            pc    = excPc;
            num   = 5'd0;
            value = {27'd0, excCode};
        end else begin
            kind  = EV_TRACE;
            pc    = trace.pc;
            num   = trace.wnum;
            value = trace.wdata;
        end
    endtask

    task automatic compareRow(input int idx, input evKind_t kind, input word_t pc,
                              input regAddr_t num, input word_t value,
                              input logic [3:0] wen);
        progRow_t exp;
        exp = rows[idx];
        checked++;
        if (kind != exp.kind) begin
            errors++;
            $display("MISMATCH at %0t: row %0d expected %s at pc %h, got %s at pc %h",
                     $time, idx, kindText(exp.kind), exp.pc, kindText(kind), pc);
        end else if (pc != exp.pc) begin
            errors++;
            $display("MISMATCH at %0t: row %0d expected pc %h, got pc %h",
                     $time, idx, exp.pc, pc);
        end else if ((kind == EV_EXC) && (value != exp.value)) begin
            errors++;
            $display("MISMATCH at %0t: pc %h expected exception code %h, got %h",
                     $time, pc, exp.value[4:0], value[4:0]);
        end else if ((num != exp.num) || (value != exp.value)) begin
            errors++;
            $display("MISMATCH at %0t: pc %h expected r%0d = %h, got r%0d = %h",
                     $time, pc, exp.num, exp.value, num, value);
        end else if ((kind == EV_TRACE) && (wen != 4'b1111)) begin
            errors++;
            $display("MISMATCH at %0t: pc %h expected write enable 1111, got %b",
                     $time, pc, wen);
        end
    endtask

    ////////////////////////////////////////
    // Main sequence
    ////////////////////////////////////////
    initial begin
        void'($urandom(SEED));  // Seed once
        rst        = 1'b1;
        wbAck      = 1'b0;
        wbDat      = '0;
        errors     = 0;
        checked    = 0;
        curRow     = 0;
        tableReady = 1'b0;
        buildProgram();
        foreach (rows[i]) begin
            progMem[rows[i].pc] = rows[i].instr;
        end
        waitLeft   = $urandom % 4;
        tableReady = 1'b1;

        repeat (RESET_CYCLES) @(posedge clk);
        rst <= 1'b0;

        foreach (rows[i]) begin
            if (rows[i].kind != EV_NONE) begin
                curRow = i;
                waitEvent(gotKind, gotPc, gotNum, gotValue, gotWen);
                compareRow(i, gotKind, gotPc, gotNum, gotValue, gotWen);
            end
        end

        // Fill code only writes $zero so no more events may show up
        repeat (QUIET_CYCLES) begin
            @(negedge clk);
            if (excValid || (trace.wen != 4'b0000)) begin
                errors++;
                $display("Unexpected event at %0t after the last table row, pc %h",
                         $time, excValid ? excPc : trace.pc);
            end
        end

        $display("Errors: %0d, events checked: %0d", errors, checked);
        if (errors == 0) begin
            $display("TESTBENCH PASSED");
        end else begin
            $display("TESTBENCH FAILED");
        end
        $finish;
    end

    // Watchdog
    initial begin
        wait (tableReady);
        repeat (rows.size() * ROW_CYCLES) @(posedge clk);
        errors++;
        $display("Timeout at %0t: row %0d (pc %h) never produced its event",
                 $time, curRow, rows[curRow].pc);
        $display("Errors: %0d, events checked: %0d", errors, checked);
        $display("TESTBENCH FAILED");
        $finish;
    end

endmodule

// File: mipsPipe.f
design/mipsTypesPkg.sv
design/pipeTypesPkg.sv
design/instrFetch.sv
design/instrDecode.sv
design/regFile.sv
design/aluExecute.sv
design/resultStage.sv
design/mipsPipe.sv
tests/mipsPipe_asserts.sv
tests/mipsPipe_tb.sv

// File: Makefile
# Verilator build and run of the mipsPipe testbench

VERILATOR ?= verilator
TOP       ?= mipsPipe_tb
FILELIST  ?= mipsPipe.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0
PASS_TEXT ?= TESTBENCH PASSED

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR) -o $(TOP)

# Fails unless the pass line shows up in the simulation output
run: compile
	@out="$$($(BUILD_DIR)/$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_TEXT)"

clean:
	rm -rf $(BUILD_DIR)
